//--- dmaController.f
+incdir+.
dmaRegPkg.sv
dmaCtrlPkg.sv
dmaRegFile.sv
dmaPriority.sv
dmaTiming.sv
dmaController.sv
dmaController_checker.sv
dmaTb.sv

//--- Makefile
# Verilator build and run of the DMA controller testbench

VERILATOR ?= verilator
TOP       ?= dmaTb
FILELIST  ?= dmaController.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dmaTb.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaTb
  import dmaRegPkg::*;
();

  localparam int Timeout     = 64;
  localparam int QuietCycles = 24;

  logic                     busIf;
  logic                     arstN;
  logic                     wbCyc;
  logic                     wbStb;
  logic                     wbWe;
  logic [`DMA_WB_ADR_W-1:0] wbAdr;
  logic [`DMA_DATA_W-1:0]   wbDatI;
  logic [`DMA_DATA_W-1:0]   wbDatO;
  logic                     wbAck;
  logic [`DMA_CHANNELS-1:0] dreq;
  logic [`DMA_CHANNELS-1:0] dack;
  logic                     hrq;
  logic                     hlda;
  logic                     aen;
  logic                     adstb;
  logic [`DMA_ADDR_W-1:0]   addr;
  logic                     iorN;
  logic                     iowN;
  logic                     memrN;
  logic                     memwN;
  logic                     eopN;

  dmaController dmaController_inst (
    .busIf  (busIf),
    .arstN  (arstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatI (wbDatI),
    .wbDatO (wbDatO),
    .wbAck  (wbAck),
    .dreq   (dreq),
    .dack   (dack),
    .hrq    (hrq),
    .hlda   (hlda),
    .aen    (aen),
    .adstb  (adstb),
    .addr   (addr),
    .iorN   (iorN),
    .iowN   (iowN),
    .memrN  (memrN),
    .memwN  (memwN),
    .eopN   (eopN)
  );

  initial begin
    busIf = 1'b0;
    forever #4 busIf = ~busIf;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic checkByte(input string name, input logic [`DMA_DATA_W-1:0] exp,
                           input logic [`DMA_DATA_W-1:0] act);
    if (act !== exp) begin
      abortRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkAddr(input string name, input logic [`DMA_ADDR_W-1:0] exp,
                           input logic [`DMA_ADDR_W-1:0] act);
    if (act !== exp) begin
      abortRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkDack(input string name, input logic [`DMA_CHANNELS-1:0] exp,
                           input logic [`DMA_CHANNELS-1:0] act);
    if (act !== exp) begin
      abortRun($sformatf("ERROR %s: expected dack %b, actual %b", name, exp, act));
    end
  endtask

  // seen is {eop, ior, iow, memr, memw} with a bit set when that line went low
  task automatic checkStrobes(input string name, input dmaXferType xt, input logic eopExp,
                              input logic [4:0] seen);
    logic [4:0] exp;
    case (xt)
      write:   exp = 5'b01001;
      read:    exp = 5'b00110;
      default: exp = 5'b00000;
    endcase
    exp[4] = eopExp;
    if (seen !== exp) begin
      abortRun($sformatf("ERROR %s: expected strobes %b, actual %b", name, exp, seen));
    end
  endtask

  // bus grant model of the host CPU
  task automatic respondHlda();
    int delay;
    delay = -1;
    forever begin
      @(posedge busIf);
      #1;
      if (!hrq) begin
        hlda  = 1'b0;
        delay = -1;
      end else if (!hlda) begin
        if (delay < 0) begin
          delay = int'($urandom_range(3, 0));
        end
        if (delay == 0) begin
          hlda = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  endtask

  initial respondHlda();

  task automatic applyReset();
    @(posedge busIf);
    #1;
    arstN = 1'b0;
    dreq  = '0;
    repeat (8) @(posedge busIf);
    #1;
    arstN = 1'b1;
  endtask

  task automatic waitAck(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge busIf);
      #1;
      cycles++;
      if (cycles > Timeout) begin
        abortRun($sformatf("no wbAck within %0d cycles on a %s", Timeout, what));
      end
    end while (!wbAck);
  endtask

  task automatic wbWrite(input dmaRegAddr adr, input logic [`DMA_DATA_W-1:0] data);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = adr;
    wbDatI = data;
    waitAck("write");
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbRead(input dmaRegAddr adr, output logic [`DMA_DATA_W-1:0] data);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = adr;
    waitAck("read");
    data  = wbDatO;
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  function automatic dmaRegAddr regForAddr(input int ch);
    return dmaRegAddr'(`DMA_WB_ADR_W'(2 * ch));
  endfunction

  function automatic dmaRegAddr regForCount(input int ch);
    return dmaRegAddr'(`DMA_WB_ADR_W'(2 * ch + 1));
  endfunction

  // byte pointer is cleared so that each word goes low byte first
  task automatic writeWord(input dmaRegAddr adr, input logic [`DMA_ADDR_W-1:0] value);
    wbWrite(clearFlipFlop, '0);
    wbWrite(adr, value[`DMA_DATA_W-1:0]);
    wbWrite(adr, value[`DMA_ADDR_W-1:`DMA_DATA_W]);
  endtask

  task automatic readWord(input dmaRegAddr adr, output logic [`DMA_ADDR_W-1:0] value);
    logic [`DMA_DATA_W-1:0] lo;
    logic [`DMA_DATA_W-1:0] hi;
    wbWrite(clearFlipFlop, '0);
    wbRead(adr, lo);
    wbRead(adr, hi);
    value = {hi, lo};
  endtask

  task automatic programChannel(input int ch, input logic [`DMA_ADDR_W-1:0] startAddr,
                                input logic [`DMA_ADDR_W-1:0] count, input dmaXferType xt,
                                input logic autoInit, input logic decrement);
    logic [`DMA_CH_W-1:0] chSel;
    chSel = ch[`DMA_CH_W-1:0];
    writeWord(regForAddr(ch), startAddr);
    writeWord(regForCount(ch), count);
    wbWrite(modeWrite, {2'b00, decrement, autoInit, xt, chSel});
    // bit 2 low clears the mask
    wbWrite(singleMask, {6'b000000, chSel});
  endtask

  // follows one transfer from adstb until aen falls back in SI
  task automatic runTransfer(input logic dropReq, output logic [`DMA_ADDR_W-1:0] addrSeen,
                             output logic [`DMA_CHANNELS-1:0] dackSeen,
                             output logic [4:0] strobeSeen);
    int cycles;
    cycles = 0;
    while (adstb !== 1'b1) begin
      if (cycles == Timeout) begin
        abortRun("no transfer started before the timeout");
      end
      @(posedge busIf);
      #1;
      cycles++;
    end
    addrSeen   = addr;
    dackSeen   = dack;
    strobeSeen = '0;
    if (dropReq) begin
      dreq = '0;
    end
    cycles = 0;
    while (aen === 1'b1) begin
      strobeSeen |= {~eopN, ~iorN, ~iowN, ~memrN, ~memwN};
      if (cycles == Timeout) begin
        abortRun("a transfer did not end before the timeout");
      end
      @(posedge busIf);
      #1;
      cycles++;
    end
  endtask

  task automatic expectNoHrq(input string name);
    for (int i = 0; i < QuietCycles; i++) begin
      @(posedge busIf);
      #1;
      if (hrq) begin
        abortRun($sformatf("%s: hrq rose although no transfer should start", name));
      end
    end
  endtask

  task automatic resetDefaults();
    logic [`DMA_DATA_W-1:0] status;
    logic [`DMA_ADDR_W-1:0] count;
    applyReset();
    checkByte("resetDefaults", 8'h00, {5'b00000, hrq, aen, adstb});
    checkDack("resetDefaults", '0, dack);
    checkStrobes("resetDefaults", verify, 1'b0, {~eopN, ~iorN, ~iowN, ~memrN, ~memwN});
    wbRead(cmdStatus, status);
    checkByte("resetDefaults", 8'h00, status);
    for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
      readWord(regForCount(ch), count);
      checkAddr("resetDefaults", '0, count);
    end
  endtask

  task automatic programReadback();
    logic [`DMA_ADDR_W-1:0] addrVal  [`DMA_CHANNELS];
    logic [`DMA_ADDR_W-1:0] countVal [`DMA_CHANNELS];
    logic [`DMA_ADDR_W-1:0] got;
    for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
      addrVal[ch]  = `DMA_ADDR_W'($urandom);
      countVal[ch] = `DMA_ADDR_W'($urandom);
      writeWord(regForAddr(ch), addrVal[ch]);
      writeWord(regForCount(ch), countVal[ch]);
    end
    for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
      readWord(regForAddr(ch), got);
      checkAddr("programReadback", addrVal[ch], got);
      readWord(regForCount(ch), got);
      checkAddr("programReadback", countVal[ch], got);
    end
  endtask

  task automatic singleTransfer();
    int                       ch;
    dmaXferType               xt;
    logic [`DMA_ADDR_W-1:0]   startAddr;
    logic [`DMA_ADDR_W-1:0]   startCount;
    logic [`DMA_ADDR_W-1:0]   expAddr;
    logic [`DMA_ADDR_W-1:0]   got;
    logic [`DMA_ADDR_W-1:0]   addrSeen;
    logic [`DMA_CHANNELS-1:0] dackSeen;
    logic [4:0]               strobeSeen;
    ch = 0;
    for (int t = 0; t < 3; t++) begin
      for (int dec = 0; dec < 2; dec++) begin
        xt         = dmaXferType'(2'(t));
        startAddr  = `DMA_ADDR_W'($urandom);
        // nonzero count keeps this away from terminal count
        startCount = `DMA_ADDR_W'($urandom_range(16'hFFFF, 1));
        programChannel(ch, startAddr, startCount, xt, 1'b0, dec[0]);
        dreq[ch] = 1'b1;
        runTransfer(1'b1, addrSeen, dackSeen, strobeSeen);
        checkAddr("singleTransfer", startAddr, addrSeen);
        checkDack("singleTransfer", `DMA_CHANNELS'(1) << ch, dackSeen);
        checkStrobes("singleTransfer", xt, 1'b0, strobeSeen);
        expAddr = dec[0] ? startAddr - 16'd1 : startAddr + 16'd1;
        readWord(regForAddr(ch), got);
        checkAddr("singleTransfer", expAddr, got);
        readWord(regForCount(ch), got);
        checkAddr("singleTransfer", startCount - 16'd1, got);
        ch = (ch + 1) % `DMA_CHANNELS;
      end
    end
  endtask

  task automatic terminalCount();
    logic [`DMA_ADDR_W-1:0]   base;
    logic [`DMA_ADDR_W-1:0]   got;
    logic [`DMA_ADDR_W-1:0]   addrSeen;
    logic [`DMA_CHANNELS-1:0] dackSeen;
    logic [4:0]               strobeSeen;
    logic [`DMA_DATA_W-1:0]   status;
    // count 1 gives two transfers with eop only in the second
    base = `DMA_ADDR_W'($urandom);
    programChannel(2, base, 16'd1, write, 1'b0, 1'b0);
    for (int n = 0; n < 2; n++) begin
      dreq[2] = 1'b1;
      runTransfer(1'b1, addrSeen, dackSeen, strobeSeen);
      checkStrobes("terminalCount", write, n == 1, strobeSeen);
    end
    wbRead(cmdStatus, status);
    checkByte("terminalCount", 8'h01 << 2, status);
    wbRead(cmdStatus, status);
    checkByte("terminalCount", 8'h00, status);
    // channel is masked now
    dreq[2] = 1'b1;
    expectNoHrq("terminalCount");
    // the held request shows in the upper status bits
    wbRead(cmdStatus, status);
    checkByte("terminalCount request", 8'h40, status);
    dreq = '0;
    base = `DMA_ADDR_W'($urandom);
    programChannel(2, base, 16'd1, read, 1'b1, 1'b0);
    for (int n = 0; n < 2; n++) begin
      dreq[2] = 1'b1;
      runTransfer(1'b1, addrSeen, dackSeen, strobeSeen);
      checkStrobes("terminalCount autoinit", read, n == 1, strobeSeen);
    end
    readWord(regForAddr(2), got);
    checkAddr("terminalCount autoinit", base, got);
    readWord(regForCount(2), got);
    checkAddr("terminalCount autoinit", 16'd1, got);
  endtask

  task automatic priorityOrder();
    logic [`DMA_ADDR_W-1:0]   addrSeen;
    logic [`DMA_CHANNELS-1:0] dackSeen;
    logic [`DMA_CHANNELS-1:0] expDack;
    logic [4:0]               strobeSeen;
    for (int pass = 0; pass < 2; pass++) begin
      // fresh reset puts the rotating pointer back on channel 0
      applyReset();
      if (pass == 1) begin
        wbWrite(cmdStatus, 8'h10);
      end
      for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
        programChannel(ch, `DMA_ADDR_W'(ch * 256), 16'd8, verify, 1'b0, 1'b0);
      end
      dreq = '1;
      for (int i = 0; i < `DMA_CHANNELS; i++) begin
        runTransfer(1'b0, addrSeen, dackSeen, strobeSeen);
        expDack = (pass == 0) ? `DMA_CHANNELS'(1) : `DMA_CHANNELS'(1) << i;
        checkDack(pass == 0 ? "priorityOrder fixed" : "priorityOrder rotating",
                  expDack, dackSeen);
      end
      dreq = '0;
    end
  endtask

  task automatic controllerDisable();
    logic [`DMA_ADDR_W-1:0]   base;
    logic [`DMA_ADDR_W-1:0]   addrSeen;
    logic [`DMA_CHANNELS-1:0] dackSeen;
    logic [4:0]               strobeSeen;
    base = `DMA_ADDR_W'($urandom);
    wbWrite(cmdStatus, 8'h04);
    programChannel(1, base, 16'd5, write, 1'b0, 1'b0);
    dreq[1] = 1'b1;
    expectNoHrq("controllerDisable");
    wbWrite(cmdStatus, 8'h00);
    runTransfer(1'b1, addrSeen, dackSeen, strobeSeen);
    checkDack("controllerDisable", 4'b0010, dackSeen);
    checkAddr("controllerDisable", base, addrSeen);
  endtask

  initial begin
    void'($urandom(32'h5097));
    arstN   = 1'b0;
    wbCyc   = 1'b0;
    wbStb   = 1'b0;
    wbWe    = 1'b0;
    wbAdr   = '0;
    wbDatI  = '0;
    dreq    = '0;
    hlda    = 1'b0;
    resetDefaults();
    programReadback();
    singleTransfer();
    terminalCount();
    priorityOrder();
    controllerDisable();
    if (dmaController_inst.assertInst.failCount == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abortRun("the bound checker reported assertion failures");
    end
  end

endmodule

//--- dmaController_checker.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaController_checker
  import dmaCtrlPkg::*;
(
  input logic                     busIf,
  input logic                     arstN,
  input dmaState                  state,
  input logic                     hrq,
  input logic                     aen,
  input logic [`DMA_CHANNELS-1:0] dack,
  input logic                     iorN,
  input logic                     iowN,
  input logic                     memrN,
  input logic                     memwN
);

  // number of failed assertions
  int failCount = 0;

  task automatic noteFailure(input string what);
    failCount++;
    $error("%s", what);
  endtask

  // SI and S0 may wait while the rest step once per cycle
  assert property (@(posedge busIf) disable iff (!arstN)
    (state == SI) |=> (state == SI || state == S0))
    else noteFailure("state left SI for a state other than S0");
  assert property (@(posedge busIf) disable iff (!arstN)
    (state == S0) |=> (state == S0 || state == S1))
    else noteFailure("state left S0 for a state other than S1");
  assert property (@(posedge busIf) disable iff (!arstN)
    (state == S1) |=> (state == S2))
    else noteFailure("S1 was not followed by S2");
  assert property (@(posedge busIf) disable iff (!arstN)
    (state == S2) |=> (state == S4))
    else noteFailure("S2 was not followed by S4");
  assert property (@(posedge busIf) disable iff (!arstN)
    (state == S4) |=> (state == SI))
    else noteFailure("S4 was not followed by SI");

  assert property (@(posedge busIf) disable iff (!arstN) $onehot0(dack))
    else noteFailure("dack has more than one bit set");
  assert property (@(posedge busIf) disable iff (!arstN) (dack != '0) |-> aen)
    else noteFailure("dack active while aen is low");
  // no strobe may reach the bus before it is handed over
  assert property (@(posedge busIf) disable iff (!arstN)
    (!iorN || !iowN || !memrN || !memwN) |-> aen)
    else noteFailure("a strobe is low while aen is low");
  assert property (@(posedge busIf) $rose(arstN) |-> !hrq)
    else noteFailure("hrq high on the first edge after reset");

endmodule

bind dmaController dmaController_checker assertInst (
  .busIf (busIf),
  .arstN (arstN),
  .state (timingInst.state),
  .hrq   (hrq),
  .aen   (aen),
  .dack  (dack),
  .iorN  (iorN),
  .iowN  (iowN),
  .memrN (memrN),
  .memwN (memwN)
);

//--- dmaController.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaController
  import dmaRegPkg::*, dmaCtrlPkg::*;
(
  input  logic                     busIf,
  input  logic                     arstN,
  input  logic                     wbCyc,
  input  logic                     wbStb,
  input  logic                     wbWe,
  input  logic [`DMA_WB_ADR_W-1:0] wbAdr,
  input  logic [`DMA_DATA_W-1:0]   wbDatI,
  output logic [`DMA_DATA_W-1:0]   wbDatO,
  output logic                     wbAck,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic                     hrq,
  input  logic                     hlda,
  output logic                     aen,
  output logic                     adstb,
  output logic [`DMA_ADDR_W-1:0]   addr,
  output logic                     iorN,
  output logic                     iowN,
  output logic                     memrN,
  output logic                     memwN,
  output logic                     eopN
);

  logic [`DMA_CHANNELS-1:0] mask;
  dmaPriorityType           priorityType;
  logic                     ctrlDisable;
  logic [`DMA_CH_W-1:0]     grantCh;
  logic                     reqValid;
  logic [`DMA_CH_W-1:0]     activeCh;
  logic                     xferDone;
  dmaXferType               xferType;
  logic                     lastXfer;

  dmaRegFile regFileInst (
    .busIf        (busIf),
    .arstN        (arstN),
    .wbCyc        (wbCyc),
    .wbStb        (wbStb),
    .wbWe         (wbWe),
    .wbAdr        (wbAdr),
    .wbDatI       (wbDatI),
    .wbDatO       (wbDatO),
    .wbAck        (wbAck),
    .dreq         (dreq),
    .activeCh     (activeCh),
    .xferDone     (xferDone),
    .mask         (mask),
    .priorityType (priorityType),
    .ctrlDisable  (ctrlDisable),
    .xferType     (xferType),
    .lastXfer     (lastXfer),
    .addr         (addr)
  );

  dmaPriority priorityInst (
    .busIf        (busIf),
    .arstN        (arstN),
    .dreq         (dreq),
    .mask         (mask),
    .priorityType (priorityType),
    .ctrlDisable  (ctrlDisable),
    .xferDone     (xferDone),
    .grantCh      (grantCh),
    .reqValid     (reqValid)
  );

  dmaTiming timingInst (
    .busIf    (busIf),
    .arstN    (arstN),
    .reqValid (reqValid),
    .grantCh  (grantCh),
    .hlda     (hlda),
    .xferType (xferType),
    .lastXfer (lastXfer),
    .hrq      (hrq),
    .aen      (aen),
    .adstb    (adstb),
    .dack     (dack),
    .activeCh (activeCh),
    .xferDone (xferDone),
    .iorN     (iorN),
    .iowN     (iowN),
    .memrN    (memrN),
    .memwN    (memwN),
    .eopN     (eopN)
  );

endmodule

//--- dmaTiming.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaTiming
  import dmaRegPkg::*, dmaCtrlPkg::*;
(
  input  logic                     busIf,
  input  logic                     arstN,
  input  logic                     reqValid,
  input  logic [`DMA_CH_W-1:0]     grantCh,
  input  logic                     hlda,
  input  dmaXferType               xferType,
  input  logic                     lastXfer,
  output logic                     hrq,
  output logic                     aen,
  output logic                     adstb,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic [`DMA_CH_W-1:0]     activeCh,
  output logic                     xferDone,
  output logic                     iorN,
  output logic                     iowN,
  output logic                     memrN,
  output logic                     memwN,
  output logic                     eopN
);

  dmaState                  state;
  logic [`DMA_CHANNELS-1:0] chOneHot;

  assign chOneHot = {{(`DMA_CHANNELS-1){1'b0}}, 1'b1} << activeCh;

  // outputs are set on the edge that enters each state
  always_ff @(posedge busIf or negedge arstN) begin
    if (!arstN) begin
      state    <= SI;
      activeCh <= '0;
      hrq      <= 1'b0;
      aen      <= 1'b0;
      adstb    <= 1'b0;
      dack     <= '0;
      xferDone <= 1'b0;
      iorN     <= 1'b1;
      iowN     <= 1'b1;
      memrN    <= 1'b1;
      memwN    <= 1'b1;
      eopN     <= 1'b1;
    end else begin
      case (state)
        SI: begin
          if (reqValid) begin
            state    <= S0;
            activeCh <= grantCh;
            hrq      <= 1'b1;
          end
        end
        // wait for the bus to be handed over
        S0: begin
          if (hlda) begin
            state <= S1;
            aen   <= 1'b1;
            adstb <= 1'b1;
            dack  <= chOneHot;
          end
        end
        S1: begin
          state <= S2;
          adstb <= 1'b0;
          // read strobe of the source side
          case (xferType)
            write:   iorN  <= 1'b0;
            read:    memrN <= 1'b0;
            default: ;
          endcase
        end
        S2: begin
          state    <= S4;
          xferDone <= 1'b1;
          eopN     <= !lastXfer;
          case (xferType)
            write:   memwN <= 1'b0;
            read:    iowN  <= 1'b0;
            default: ;
          endcase
        end
        S4: begin
          state    <= SI;
          hrq      <= 1'b0;
          aen      <= 1'b0;
          dack     <= '0;
          xferDone <= 1'b0;
          iorN     <= 1'b1;
          iowN     <= 1'b1;
          memrN    <= 1'b1;
          memwN    <= 1'b1;
          eopN     <= 1'b1;
        end
        default: state <= SI;
      endcase
    end
  end

endmodule

//--- dmaPriority.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaPriority
  import dmaCtrlPkg::*;
(
  input  logic                     busIf,
  input  logic                     arstN,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [`DMA_CHANNELS-1:0] mask,
  input  dmaPriorityType           priorityType,
  input  logic                     ctrlDisable,
  input  logic                     xferDone,
  output logic [`DMA_CH_W-1:0]     grantCh,
  output logic                     reqValid
);

  localparam int ChW = `DMA_CH_W;

  logic [`DMA_CHANNELS-1:0] pending;
  // highest priority channel in rotating mode
  logic [ChW-1:0]           rotPtr;
  logic [ChW-1:0]           startCh;
  logic [ChW-1:0]           servedCh;
  // mirrors the timing block being away from SI
  logic                     busy;

  assign pending = dreq & ~mask;
  assign startCh = (priorityType == rotatingPri) ? rotPtr : '0;

  always_comb begin
    logic [ChW-1:0] idx;
    grantCh  = '0;
    reqValid = 1'b0;
    // index wraps around the channel count
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      idx = startCh + ChW'(i);
      if (!reqValid && pending[idx]) begin
        reqValid = 1'b1;
        grantCh  = idx;
      end
    end
    if (ctrlDisable) begin
      reqValid = 1'b0;
    end
  end

  // remember which channel the timing block took, the grant may move meanwhile
  always_ff @(posedge busIf or negedge arstN) begin
    if (!arstN) begin
      busy     <= 1'b0;
      servedCh <= '0;
      rotPtr   <= '0;
    end else if (xferDone) begin
      busy   <= 1'b0;
      rotPtr <= servedCh + 1'b1;
    end else if (!busy && reqValid) begin
      busy     <= 1'b1;
      servedCh <= grantCh;
    end
  end

endmodule

//--- dmaRegFile.sv
`timescale 1ns/1ps
`include "dma_macros.svh"

module dmaRegFile
  import dmaRegPkg::*, dmaCtrlPkg::*;
(
  input  logic                     busIf,
  input  logic                     arstN,
  input  logic                     wbCyc,
  input  logic                     wbStb,
  input  logic                     wbWe,
  input  logic [`DMA_WB_ADR_W-1:0] wbAdr,
  input  logic [`DMA_DATA_W-1:0]   wbDatI,
  output logic [`DMA_DATA_W-1:0]   wbDatO,
  output logic                     wbAck,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [`DMA_CH_W-1:0]     activeCh,
  input  logic                     xferDone,
  output logic [`DMA_CHANNELS-1:0] mask,
  output dmaPriorityType           priorityType,
  output logic                     ctrlDisable,
  output dmaXferType               xferType,
  output logic                     lastXfer,
  output logic [`DMA_ADDR_W-1:0]   addr
);

  logic [`DMA_ADDR_W-1:0]   baseAddr  [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curAddr   [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   baseCount [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curCount  [`DMA_CHANNELS];
  dmaXferType               modeType  [`DMA_CHANNELS];
  logic [`DMA_CHANNELS-1:0] autoInit;
  logic [`DMA_CHANNELS-1:0] decrement;
  logic [`DMA_CHANNELS-1:0] tcStatus;
  logic [`DMA_CHANNELS-1:0] reqLatch;
  // byte pointer, high byte when set
  logic                     byteFf;
  logic                     access;
  dmaRegAddr                regSel;
  logic [`DMA_CH_W-1:0]     regCh;
  logic [`DMA_DATA_W-1:0]   rdData;

  // a new access is one the slave has not yet acknowledged
  assign access = wbCyc && wbStb && !wbAck;
  assign regSel = dmaRegAddr'(wbAdr);
  assign regCh  = wbAdr[`DMA_CH_W:1];

  always_comb begin
    case (regSel)
      chAddr0, chAddr1, chAddr2, chAddr3:
        rdData = byteFf ? curAddr[regCh][`DMA_ADDR_W-1:`DMA_DATA_W]
                        : curAddr[regCh][`DMA_DATA_W-1:0];
      chCount0, chCount1, chCount2, chCount3:
        rdData = byteFf ? curCount[regCh][`DMA_ADDR_W-1:`DMA_DATA_W]
                        : curCount[regCh][`DMA_DATA_W-1:0];
      // request bits on top, terminal count below
      cmdStatus:
        rdData = {reqLatch, tcStatus};
      default:
        rdData = '0;
    endcase
  end

  always_ff @(posedge busIf or negedge arstN) begin
    if (!arstN) begin
      wbAck        <= 1'b0;
      wbDatO       <= '0;
      byteFf       <= 1'b0;
      ctrlDisable  <= 1'b0;
      priorityType <= fixedPri;
      mask         <= '1;
      tcStatus     <= '0;
      reqLatch     <= '0;
      autoInit     <= '0;
      decrement    <= '0;
      for (int i = 0; i < `DMA_CHANNELS; i++) begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
        modeType[i]  <= verify;
      end
    end else begin
      wbAck    <= access;
      reqLatch <= dreq;
      if (access) begin
        wbDatO <= rdData;
        // every address or count access flips the byte pointer
        if (regSel inside {chAddr0, chAddr1, chAddr2, chAddr3,
                           chCount0, chCount1, chCount2, chCount3}) begin
          byteFf <= !byteFf;
        end
        if (wbWe) begin
          case (regSel)
            chAddr0, chAddr1, chAddr2, chAddr3: begin
              if (byteFf) begin
                baseAddr[regCh][`DMA_ADDR_W-1:`DMA_DATA_W] <= wbDatI;
                curAddr[regCh][`DMA_ADDR_W-1:`DMA_DATA_W]  <= wbDatI;
              end else begin
                baseAddr[regCh][`DMA_DATA_W-1:0] <= wbDatI;
                curAddr[regCh][`DMA_DATA_W-1:0]  <= wbDatI;
              end
            end
            chCount0, chCount1, chCount2, chCount3: begin
              if (byteFf) begin
                baseCount[regCh][`DMA_ADDR_W-1:`DMA_DATA_W] <= wbDatI;
                curCount[regCh][`DMA_ADDR_W-1:`DMA_DATA_W]  <= wbDatI;
              end else begin
                baseCount[regCh][`DMA_DATA_W-1:0] <= wbDatI;
                curCount[regCh][`DMA_DATA_W-1:0]  <= wbDatI;
              end
            end
            cmdStatus: begin
              ctrlDisable  <= wbDatI[2];
              priorityType <= dmaPriorityType'(wbDatI[4]);
            end
            singleMask:
              mask[wbDatI[`DMA_CH_W-1:0]] <= wbDatI[2];
            modeWrite: begin
              modeType[wbDatI[`DMA_CH_W-1:0]]  <= dmaXferType'(wbDatI[3:2]);
              autoInit[wbDatI[`DMA_CH_W-1:0]]  <= wbDatI[4];
              decrement[wbDatI[`DMA_CH_W-1:0]] <= wbDatI[5];
            end
            clearFlipFlop:
              byteFf <= 1'b0;
            // same control state as a hardware reset
            masterClear: begin
              byteFf       <= 1'b0;
              ctrlDisable  <= 1'b0;
              priorityType <= fixedPri;
              mask         <= '1;
              tcStatus     <= '0;
            end
            default: ;
          endcase
        end else if (regSel == cmdStatus) begin
          tcStatus <= '0;
        end
      end
      // end of S4, later assignments win over a host access on the same edge
      if (xferDone) begin
        curAddr[activeCh]  <= decrement[activeCh] ? curAddr[activeCh] - 1'b1
                                                  : curAddr[activeCh] + 1'b1;
        curCount[activeCh] <= curCount[activeCh] - 1'b1;
        if (lastXfer) begin
          tcStatus[activeCh] <= 1'b1;
          if (autoInit[activeCh]) begin
            curAddr[activeCh]  <= baseAddr[activeCh];
            curCount[activeCh] <= baseCount[activeCh];
          end else begin
            mask[activeCh] <= 1'b1;
          end
        end
      end
    end
  end

  assign xferType = modeType[activeCh];
  // count of zero means this is the final transfer
  assign lastXfer = (curCount[activeCh] == '0);
  assign addr     = curAddr[activeCh];

endmodule

//--- dmaCtrlPkg.sv
package dmaCtrlPkg;

  // one-hot timing states of a single transfer
  typedef enum logic [4:0] {
    SI = 5'b00001,
    S0 = 5'b00010,
    S1 = 5'b00100,
    S2 = 5'b01000,
    S4 = 5'b10000
  } dmaState;

  // command register bit 4
  typedef enum logic {
    fixedPri    = 1'b0,
    rotatingPri = 1'b1
  } dmaPriorityType;

endpackage

//--- dmaRegPkg.sv
`include "dma_macros.svh"

package dmaRegPkg;

  // host-visible register map
  typedef enum logic [`DMA_WB_ADR_W-1:0] {
    chAddr0       = 4'd0,
    chCount0      = 4'd1,
    chAddr1       = 4'd2,
    chCount1      = 4'd3,
    chAddr2       = 4'd4,
    chCount2      = 4'd5,
    chAddr3       = 4'd6,
    chCount3      = 4'd7,
    cmdStatus     = 4'd8,
    singleMask    = 4'd10,
    modeWrite     = 4'd11,
    clearFlipFlop = 4'd12,
    masterClear   = 4'd13
  } dmaRegAddr;

  // write moves I/O to memory, read moves memory to I/O
  typedef enum logic [1:0] {
    verify = 2'b00,
    write  = 2'b01,
    read   = 2'b10
  } dmaXferType;

endpackage

//--- dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// number of request/acknowledge channels
`define DMA_CHANNELS 4

// channel index width
`define DMA_CH_W $clog2(`DMA_CHANNELS)

// address and word count register width, also the addr output
`define DMA_ADDR_W 16

// wishbone data and address widths
`define DMA_DATA_W 8
`define DMA_WB_ADR_W 4

`endif
